/* rtl/dcache_pkg.sv */
package dcache_pkg;

    // default geometry, overridden from the top level
    parameter int DEF_INDEX_W  = 4;
    parameter int DEF_OFFSET_W = 2;

    //////////////////////////////////////////////////////////////////////
    // pipeline request
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
        logic        uncached;
        logic        inval_all;
    } dcache_req_t;

    //////////////////////////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////////////////////////
    // line set means a whole-line read at a line-aligned address
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        write;
        logic        line;
    } mem_req_t;

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        WRITE_REQ,
        UNC_REQ,
        UNC_WAIT
    } ctrl_state_t;

endpackage

/* rtl/dcache_sweep_counter.sv */
`timescale 1ns/1ps

module dcache_sweep_counter import dcache_pkg::*; #(
    parameter int INDEX_W = DEF_INDEX_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sweep_start,
    output logic               sweep_busy,
    output logic [INDEX_W-1:0] sweep_index,
    output logic               sweep_done
);

    localparam logic [INDEX_W-1:0] LAST_INDEX = '1;

    // last set of the walk
    assign sweep_done = sweep_busy && (sweep_index == LAST_INDEX);

    // busy out of reset, so the arrays start clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_busy  <= 1'b1;
            sweep_index <= '0;
        end else if (sweep_start) begin
            sweep_busy  <= 1'b1;
            sweep_index <= '0;
        end else if (sweep_busy) begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_done) begin
                sweep_busy <= 1'b0;
            end
        end
    end

endmodule

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ps

module dcache_tag_array import dcache_pkg::*; #(
    parameter int INDEX_W  = DEF_INDEX_W,
    parameter int OFFSET_W = DEF_OFFSET_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic [31:0]        buf_addr,
    input  logic               tag_write,
    input  logic               fill_way,
    input  logic               lru_touch,
    input  logic               touch_way,
    input  logic               sweep_busy,
    input  logic [INDEX_W-1:0] sweep_index,
    output logic               hit,
    output logic               hit_way,
    output logic               victim_way
);

    localparam int SETS  = 1 << INDEX_W;
    localparam int TAG_W = 32 - INDEX_W - OFFSET_W - 2;

    logic [TAG_W-1:0]   tags [2][SETS];
    logic [1:0]         valid [SETS];
    // per set, the least recently used way
    logic [SETS-1:0]    lru;
    logic [INDEX_W-1:0] index_q;
    logic [TAG_W-1:0]   buf_tag;
    logic [1:0]         way_hit;

    assign buf_tag = buf_addr[31 -: TAG_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q <= '0;
        end else begin
            index_q <= rd_index;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // updates, sweep first
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            valid[sweep_index] <= 2'b00;
            lru[sweep_index]   <= 1'b0;
        end else begin
            if (tag_write) begin
                tags[fill_way][index_q]  <= buf_tag;
                valid[index_q][fill_way] <= 1'b1;
            end
            // the other way becomes the victim
            if (lru_touch) begin
                lru[index_q] <= ~touch_way;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // compare against the registered set
    ///////////////////////////////////////////////////////////////////////
    assign way_hit[0] = valid[index_q][0] && (tags[0][index_q] == buf_tag);
    assign way_hit[1] = valid[index_q][1] && (tags[1][index_q] == buf_tag);

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign victim_way = lru[index_q];

endmodule

/* rtl/dcache_data_array.sv */
`timescale 1ns/1ps

module dcache_data_array import dcache_pkg::*; #(
    parameter int INDEX_W  = DEF_INDEX_W,
    parameter int OFFSET_W = DEF_OFFSET_W
) (
    input  logic                       clk,
    input  logic [INDEX_W-1:0]         rd_index,
    input  logic [31:0]                buf_addr,
    input  logic [31:0]                buf_wdata,
    input  logic [3:0]                 buf_wstrb,
    input  logic                       word_write,
    input  logic                       line_fill,
    input  logic                       fill_way,
    input  logic                       rd_way,
    input  logic [(32<<OFFSET_W)-1:0]  mem_resp_line,
    output logic [31:0]                rd_word
);

    localparam int SETS   = 1 << INDEX_W;
    localparam int LINE_W = 32 << OFFSET_W;

    logic [LINE_W-1:0]   lines [2][SETS];
    logic [INDEX_W-1:0]  index_q;
    logic [OFFSET_W-1:0] word_off;
    logic [OFFSET_W-1:0] sel_off;
    logic [LINE_W-1:0]   src_line;
    logic                bypass;
    logic                fill_en;
    logic                word_en;

    assign word_off = buf_addr[2 +: OFFSET_W];

    // both enables together: uncached word passes through, storage untouched
    assign bypass  = line_fill && word_write;
    assign fill_en = line_fill && !word_write;
    assign word_en = word_write && !line_fill;

    ///////////////////////////////////////////////////////////////////////
    // storage
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        index_q <= rd_index;
        if (fill_en) begin
            lines[fill_way][index_q] <= mem_resp_line;
        end else if (word_en) begin
            for (int b = 0; b < 4; b++) begin
                if (buf_wstrb[b]) begin
                    lines[fill_way][index_q][word_off*32 + b*8 +: 8] <= buf_wdata[b*8 +: 8];
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // word select
    ///////////////////////////////////////////////////////////////////////
    // refill data is forwarded so the response can be latched at once
    assign src_line = line_fill ? mem_resp_line : lines[rd_way][index_q];
    // uncached words always sit in the low bits
    assign sel_off  = bypass ? '0 : word_off;
    assign rd_word  = src_line[sel_off*32 +: 32];

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int INDEX_W  = DEF_INDEX_W,
    parameter int OFFSET_W = DEF_OFFSET_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  dcache_req_t        req,
    output logic               req_ready,
    output logic               resp_valid,
    output logic [31:0]        resp_rdata,
    output logic               mem_req_valid,
    output mem_req_t           mem_req,
    input  logic               mem_req_ready,
    input  logic               mem_resp_valid,
    output logic [INDEX_W-1:0] rd_index,
    output logic [31:0]        buf_addr,
    output logic [31:0]        buf_wdata,
    output logic [3:0]         buf_wstrb,
    input  logic               hit,
    input  logic               hit_way,
    input  logic               victim_way,
    output logic               tag_write,
    output logic               lru_touch,
    output logic               touch_way,
    output logic               word_write,
    output logic               line_fill,
    output logic               fill_way,
    output logic               rd_way,
    output logic               sweep_start,
    input  logic               sweep_busy,
    input  logic               sweep_done,
    input  logic [31:0]        rd_word
);

    localparam int IDX_LO = OFFSET_W + 2;

    ctrl_state_t state_q;
    ctrl_state_t dispatch;
    dcache_req_t buf_q;
    logic        pend_q;
    logic        inval_q;
    logic [31:0] resp_q;
    logic        lookup;
    logic        rd_hit;
    logic        accept;
    logic        refill;
    logic        unc_done;

    assign lookup   = (state_q == LOOKUP);
    assign rd_hit   = lookup && hit && !buf_q.write;
    assign refill   = (state_q == MISS_WAIT) && mem_resp_valid;
    assign unc_done = (state_q == UNC_WAIT) && mem_resp_valid;

    // a read hit frees the buffer in the cycle it answers
    assign req_ready = !sweep_busy && ((state_q == IDLE) || rd_hit);
    assign accept    = req_valid && req_ready;

    assign dispatch = req.inval_all ? SWEEP : (req.uncached ? UNC_REQ : LOOKUP);

    assign rd_index = req_ready ? req.addr[IDX_LO +: INDEX_W] : buf_q.addr[IDX_LO +: INDEX_W];

    ///////////////////////////////////////////////////////////////////////
    // state machine
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SWEEP;
            pend_q  <= 1'b0;
            inval_q <= 1'b0;
        end else begin
            pend_q <= 1'b0;
            if (accept) begin
                inval_q <= req.inval_all;
            end
            case (state_q)
                SWEEP: begin
                    if (sweep_done) begin
                        state_q <= IDLE;
                        // the reset sweep gets no response
                        pend_q  <= inval_q;
                        inval_q <= 1'b0;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state_q <= dispatch;
                    end
                end
                LOOKUP: begin
                    if (buf_q.write) begin
                        state_q <= WRITE_REQ;
                    end else if (!hit) begin
                        state_q <= MISS_REQ;
                    end else if (accept) begin
                        state_q <= dispatch;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                MISS_REQ: begin
                    if (mem_req_ready) begin
                        state_q <= MISS_WAIT;
                    end
                end
                WRITE_REQ: begin
                    if (mem_req_ready) begin
                        state_q <= IDLE;
                        pend_q  <= 1'b1;
                    end
                end
                UNC_REQ: begin
                    if (mem_req_ready) begin
                        state_q <= buf_q.write ? IDLE : UNC_WAIT;
                        pend_q  <= buf_q.write;
                    end
                end
                MISS_WAIT, UNC_WAIT: begin
                    if (mem_resp_valid) begin
                        state_q <= IDLE;
                        pend_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request buffer and latched response word
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_q <= req;
        end
        resp_q <= (refill || unc_done) ? rd_word : '0;
    end

    ///////////////////////////////////////////////////////////////////////
    // array and memory steering
    ///////////////////////////////////////////////////////////////////////
    assign buf_addr  = buf_q.addr;
    assign buf_wdata = buf_q.wdata;
    assign buf_wstrb = buf_q.wstrb;

    assign word_write  = (lookup && hit && buf_q.write) || unc_done;
    assign line_fill   = refill || unc_done;
    assign tag_write   = refill;
    assign lru_touch   = (lookup && hit) || refill;
    assign fill_way    = lookup ? hit_way : victim_way;
    assign touch_way   = fill_way;
    assign rd_way      = hit_way;
    assign sweep_start = accept && req.inval_all;

    assign resp_valid = pend_q || rd_hit;
    assign resp_rdata = pend_q ? resp_q : rd_word;

    assign mem_req_valid = (state_q == MISS_REQ) || (state_q == WRITE_REQ) ||
                           (state_q == UNC_REQ);

    always_comb begin
        mem_req       = '0;
        mem_req.addr  = buf_q.addr;
        mem_req.wdata = buf_q.wdata;
        mem_req.wstrb = buf_q.wstrb;
        mem_req.write = buf_q.write;
        // refills fetch the whole line from its first word
        if (state_q == MISS_REQ) begin
            mem_req.line             = 1'b1;
            mem_req.addr[IDX_LO-1:0] = '0;
        end
    end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_W  = DEF_INDEX_W,
    parameter int OFFSET_W = DEF_OFFSET_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  dcache_req_t               req,
    output logic                      req_ready,
    output logic                      resp_valid,
    output logic [31:0]               resp_rdata,
    output logic                      mem_req_valid,
    output mem_req_t                  mem_req,
    input  logic                      mem_req_ready,
    input  logic                      mem_resp_valid,
    input  logic [(32<<OFFSET_W)-1:0] mem_resp_line
);

    logic [INDEX_W-1:0] rd_index;
    logic [INDEX_W-1:0] sweep_index;
    logic [31:0]        buf_addr;
    logic [31:0]        buf_wdata;
    logic [3:0]         buf_wstrb;
    logic [31:0]        rd_word;
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               tag_write;
    logic               lru_touch;
    logic               touch_way;
    logic               word_write;
    logic               line_fill;
    logic               fill_way;
    logic               rd_way;
    logic               sweep_start;
    logic               sweep_busy;
    logic               sweep_done;

    dcache_ctrl #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .rd_index       (rd_index),
        .buf_addr       (buf_addr),
        .buf_wdata      (buf_wdata),
        .buf_wstrb      (buf_wstrb),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .tag_write      (tag_write),
        .lru_touch      (lru_touch),
        .touch_way      (touch_way),
        .word_write     (word_write),
        .line_fill      (line_fill),
        .fill_way       (fill_way),
        .rd_way         (rd_way),
        .sweep_start    (sweep_start),
        .sweep_busy     (sweep_busy),
        .sweep_done     (sweep_done),
        .rd_word        (rd_word)
    );

    dcache_sweep_counter #(
        .INDEX_W (INDEX_W)
    ) u_sweep (
        .clk         (clk),
        .rst_n       (rst_n),
        .sweep_start (sweep_start),
        .sweep_busy  (sweep_busy),
        .sweep_index (sweep_index),
        .sweep_done  (sweep_done)
    );

    dcache_tag_array #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) u_tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_index    (rd_index),
        .buf_addr    (buf_addr),
        .tag_write   (tag_write),
        .fill_way    (fill_way),
        .lru_touch   (lru_touch),
        .touch_way   (touch_way),
        .sweep_busy  (sweep_busy),
        .sweep_index (sweep_index),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    dcache_data_array #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) u_data (
        .clk           (clk),
        .rd_index      (rd_index),
        .buf_addr      (buf_addr),
        .buf_wdata     (buf_wdata),
        .buf_wstrb     (buf_wstrb),
        .word_write    (word_write),
        .line_fill     (line_fill),
        .fill_way      (fill_way),
        .rd_way        (rd_way),
        .mem_resp_line (mem_resp_line),
        .rd_word       (rd_word)
    );

endmodule

/* verif/dcache_mem_model.sv */
`timescale 1ns/1ps

module dcache_mem_model import dcache_pkg::*; #(
    parameter int OFFSET_W = DEF_OFFSET_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  int                        delay,
    input  logic                      mem_req_valid,
    input  mem_req_t                  mem_req,
    output logic                      mem_req_ready,
    output logic                      mem_resp_valid,
    output logic [(32<<OFFSET_W)-1:0] mem_resp_line,
    output int                        read_count,
    output int                        write_count,
    output logic                      last_line
);

    localparam int WORDS = 1 << OFFSET_W;

    // only written words are stored, the rest follow the fill rule
    logic [31:0] backing [logic [31:0]];
    logic [31:0] resp_addr;
    logic        resp_is_line;
    logic        resp_pend;
    int          resp_cnt;
    int          wait_cnt;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] aa;
        aa = {addr[31:2], 2'b00};
        if (backing.exists(aa)) begin
            return backing[aa];
        end
        return aa ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [(32<<OFFSET_W)-1:0] build_line(input logic [31:0] addr,
                                                               input logic is_line);
        logic [(32<<OFFSET_W)-1:0] l;
        l = '0;
        if (!is_line) begin
            l[31:0] = word_at(addr);
        end else begin
            for (int w = 0; w < WORDS; w++) begin
                l[w*32 +: 32] = word_at(addr + 32'(w * 4));
            end
        end
        return l;
    endfunction

    task automatic merge_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] merged;
        merged = word_at(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) merged[b*8 +: 8] = data[b*8 +: 8];
        end
        backing[{addr[31:2], 2'b00}] = merged;
    endtask

    assign mem_req_ready = mem_req_valid && !resp_pend && (wait_cnt >= delay);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt       <= 0;
            resp_pend      <= 1'b0;
            resp_cnt       <= 0;
            mem_resp_valid <= 1'b0;
            mem_resp_line  <= '0;
            read_count     <= 0;
            write_count    <= 0;
            last_line      <= 1'b0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (mem_req_valid && !mem_req_ready) wait_cnt <= wait_cnt + 1;
            if (mem_req_valid && mem_req_ready) begin
                wait_cnt <= 0;
                if (mem_req.write) begin
                    merge_write(mem_req.addr, mem_req.wdata, mem_req.wstrb);
                    write_count <= write_count + 1;
                end else begin
                    read_count   <= read_count + 1;
                    last_line    <= mem_req.line;
                    resp_addr    <= mem_req.addr;
                    resp_is_line <= mem_req.line;
                    resp_pend    <= 1'b1;
                    resp_cnt     <= 0;
                end
            end
            // read data comes back after the same programmable delay
            if (resp_pend) begin
                if (resp_cnt >= delay) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_line  <= build_line(resp_addr, resp_is_line);
                    resp_pend      <= 1'b0;
                end else begin
                    resp_cnt <= resp_cnt + 1;
                end
            end
        end
    end

endmodule

/* verif/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*;;

    localparam int INDEX_W  = DEF_INDEX_W;
    localparam int OFFSET_W = DEF_OFFSET_W;

    typedef struct {
        string       name;
        dcache_req_t req;
        int          delay;
        int          exp_reads;
        int          exp_writes;
        int          exp_lat;
    } test_entry_t;

    logic                      clk;
    logic                      rst_n;
    logic                      req_valid;
    dcache_req_t               req;
    logic                      req_ready;
    logic                      resp_valid;
    logic [31:0]               resp_rdata;
    logic                      mem_req_valid;
    mem_req_t                  mem_req;
    logic                      mem_req_ready;
    logic                      mem_resp_valid;
    logic [(32<<OFFSET_W)-1:0] mem_resp_line;
    int                        mem_delay;
    int                        read_count;
    int                        write_count;
    logic                      last_line;

    test_entry_t table_q[$];
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] lfsr_state;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;

    dcache_top #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) dut (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata), .mem_req_valid(mem_req_valid),
        .mem_req(mem_req), .mem_req_ready(mem_req_ready), .mem_resp_valid(mem_resp_valid),
        .mem_resp_line(mem_resp_line)
    );

    dcache_mem_model #(.OFFSET_W(OFFSET_W)) u_mem (
        .clk(clk), .rst_n(rst_n), .delay(mem_delay), .mem_req_valid(mem_req_valid),
        .mem_req(mem_req), .mem_req_ready(mem_req_ready), .mem_resp_valid(mem_resp_valid),
        .mem_resp_line(mem_resp_line), .read_count(read_count),
        .write_count(write_count), .last_line(last_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        @(negedge clk);
        repeat (table_q.size() * 40) @(posedge clk);
        $display("watchdog: simulation ran out of time");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] aa;
        aa = {addr[31:2], 2'b00};
        return shadow.exists(aa) ? shadow[aa] : (aa ^ 32'h5A5A_0000);
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        logic [31:0] w;
        w = shadow_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[b*8 +: 8] = data[b*8 +: 8];
        end
        shadow[{addr[31:2], 2'b00}] = w;
    endtask

    // galois lfsr stepped once for each bit taken
    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000)
                                       : (lfsr_state >> 1);
        end
        return val;
    endfunction

    task automatic add_test(input string name, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input logic [2:0] kind, input int reads, input int writes,
                            input int lat);
        test_entry_t t;
        t.name          = name;
        t.req           = '0;
        t.req.addr      = addr;
        t.req.wdata     = wdata;
        t.req.wstrb     = wstrb;
        t.req.write     = kind[2];
        t.req.uncached  = kind[1];
        t.req.inval_all = kind[0];
        t.delay         = random_bits(2);
        t.exp_reads     = reads;
        t.exp_writes    = writes;
        t.exp_lat       = lat;
        table_q.push_back(t);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%-22s ok", name);
        end else begin
            fail_cnt++;
            $display("%-22s error", name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // drive one table entry and sample on falling edges
    ////////////////////////////////////////////////////////////////////
    task automatic run_entry(input test_entry_t t);
        int          lat;
        int          guard;
        int          reads0;
        int          writes0;
        int          errs0;
        logic [31:0] exp;
        errs0     = err_cnt;
        exp       = (t.req.write || t.req.inval_all) ? 32'h0 : shadow_word(t.req.addr);
        mem_delay = t.delay;
        reads0    = read_count;
        writes0   = write_count;
        req       = t.req;
        req_valid = 1'b1;
        guard     = 0;
        while (!req_ready && guard < 100) begin
            @(negedge clk);
            guard++;
        end
        assert (req_ready) else begin
            $display("%s: request was never accepted", t.name);
            err_cnt++;
        end
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
        lat       = 1;
        while (!resp_valid && lat < 200) begin
            @(negedge clk);
            lat++;
        end
        assert (resp_valid) else begin
            $display("%s: no response, controller in %s", t.name, dut.u_ctrl.state_q.name());
            err_cnt++;
        end
        assert (resp_rdata == exp) else begin
            $display("FAIL %s data expected %h actual %h", t.name, exp, resp_rdata);
            err_cnt++;
        end
        if (t.exp_lat > 0) begin
            assert (lat == t.exp_lat) else begin
                $display("FAIL %s latency expected %0d actual %0d", t.name, t.exp_lat, lat);
                err_cnt++;
            end
        end
        assert (read_count - reads0 == t.exp_reads) else begin
            $display("FAIL %s mem reads expected %0d actual %0d", t.name, t.exp_reads,
                     read_count - reads0);
            err_cnt++;
        end
        assert (write_count - writes0 == t.exp_writes) else begin
            $display("FAIL %s mem writes expected %0d actual %0d", t.name, t.exp_writes,
                     write_count - writes0);
            err_cnt++;
        end
        // refills read whole lines and the bypass reads single words
        if (t.exp_reads > 0) begin
            assert (last_line == !t.req.uncached) else begin
                $display("FAIL %s line flag expected %b actual %b", t.name,
                         !t.req.uncached, last_line);
                err_cnt++;
            end
        end
        if (t.req.write) shadow_write(t.req.addr, t.req.wdata, t.req.wstrb);
        finish_test(t.name, errs0);
    endtask

    // two hits in a row with the second accepted while the first answers
    task automatic back_to_back_hits(input logic [31:0] a0, input logic [31:0] a1);
        int errs0;
        int reads0;
        errs0     = err_cnt;
        reads0    = read_count;
        req       = '0;
        req.addr  = a0;
        req_valid = 1'b1;
        @(negedge clk);
        req.addr = a1;
        assert (resp_valid && req_ready) else begin
            $display("back_to_back_hits: first hit did not answer with the cache ready");
            err_cnt++;
        end
        assert (resp_rdata == shadow_word(a0)) else begin
            $display("FAIL back_to_back_hits first word expected %h actual %h",
                     shadow_word(a0), resp_rdata);
            err_cnt++;
        end
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
        assert (resp_valid) else begin
            $display("back_to_back_hits: second hit gave no response in the next cycle");
            err_cnt++;
        end
        assert (resp_rdata == shadow_word(a1)) else begin
            $display("FAIL back_to_back_hits second word expected %h actual %h",
                     shadow_word(a1), resp_rdata);
            err_cnt++;
        end
        assert (read_count == reads0) else begin
            $display("FAIL back_to_back_hits mem reads expected 0 actual %0d",
                     read_count - reads0);
            err_cnt++;
        end
        finish_test("back_to_back_hits", errs0);
    endtask

    initial begin
        int cnt;
        int errs0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        mem_delay  = 0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        lfsr_state = 32'd91579;

        // kind bits are write, uncached, invalidate
        add_test("read_a_miss",        32'h1034, 0, 0,           3'b000, 1, 0, 0);
        add_test("read_a_hit",         32'h1038, 0, 0,           3'b000, 0, 0, 1);
        add_test("write_a_hit",        32'h1038, 32'hDEADBEEF, 4'b0101, 3'b100, 0, 1, 0);
        add_test("read_a_merged",      32'h1038, 0, 0,           3'b000, 0, 0, 1);
        add_test("write_miss",         32'h5000, 32'hCAFE0001, 4'b1111, 3'b100, 0, 1, 0);
        add_test("read_after_wmiss",   32'h5000, 0, 0,           3'b000, 1, 0, 0);
        add_test("read_b_miss",        32'h2030, 0, 0,           3'b000, 1, 0, 0);
        add_test("read_a_again",       32'h1030, 0, 0,           3'b000, 0, 0, 1);
        add_test("read_c_evicts_b",    32'h3030, 0, 0,           3'b000, 1, 0, 0);
        add_test("read_a_kept",        32'h1034, 0, 0,           3'b000, 0, 0, 1);
        add_test("read_b_refetch",     32'h2030, 0, 0,           3'b000, 1, 0, 0);
        add_test("unc_read",           32'h1038, 0, 0,           3'b010, 1, 0, 0);
        add_test("unc_write",          32'h6000, 32'h12345678, 4'b1111, 3'b110, 0, 1, 0);
        add_test("unc_read_back",      32'h6000, 0, 0,           3'b010, 1, 0, 0);
        add_test("read_a_cached",      32'h1038, 0, 0,           3'b000, 0, 0, 1);
        add_test("inval_all",          32'h0,    0, 0,           3'b001, 0, 0,
                 (1 << INDEX_W) + 1);
        add_test("read_a_after_inval", 32'h1038, 0, 0,           3'b000, 1, 0, 0);
        add_test("read_b_after_inval", 32'h2030, 0, 0,           3'b000, 1, 0, 0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        errs0 = err_cnt;
        cnt   = 0;
        while (!req_ready && cnt < 100) begin
            assert (!resp_valid && !mem_req_valid) else begin
                $display("reset_sweep: response or memory request during the sweep");
                err_cnt++;
            end
            @(negedge clk);
            cnt++;
        end
        assert (cnt == (1 << INDEX_W)) else begin
            $display("FAIL reset_sweep cycles expected %0d actual %0d", 1 << INDEX_W, cnt);
            err_cnt++;
        end
        finish_test("reset_sweep", errs0);

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        back_to_back_hits(32'h1030, 32'h103C);

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/dcache_pkg.sv
rtl/dcache_sweep_counter.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_mem_model.sv
verif/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		rtl/dcache_pkg.sv rtl/dcache_sweep_counter.sv rtl/dcache_tag_array.sv \
		rtl/dcache_data_array.sv rtl/dcache_ctrl.sv rtl/dcache_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
